/* Makefile */
VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= frontEnd_tb
RTL_TOP   ?= frontEnd
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell grep -v '^+' $(FLIST)) hw/frontEnd_cfg.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

$(BUILD_DIR)/$(TB_TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)

sim: $(BUILD_DIR)/$(TB_TOP)
	-./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG) || \
		! grep -q "Simulation completed successfully" $(LOG); then \
		echo "sim: FAIL"; exit 1; \
	fi
	@echo "sim: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+hw
hw/frontEndPkg.sv
hw/programCounter.sv
hw/regFile.sv
hw/instrDecoder.sv
hw/fetchSequencer.sv
hw/frontEnd.sv
testbench/frontEnd_props.sv
testbench/frontEnd_tb.sv

/* hw/fetchSequencer.sv */
`timescale 1ns/1ps
`include "frontEnd_cfg.svh"

module fetchSequencer import frontEndPkg::*; (
    input  logic          Clock,
    input  logic          rst,
    output logic          fetchValid,
    input  logic          fetchReady,
    input  logic          instrValid,
    output logic          instrReady,
    output logic          issueValid,
    input  logic          issueReady,
    input  decodedInstr_t decoded,
    input  logic [31:0]   pc,
    input  logic [31:0]   op1,
    output logic          captureEn,
    output logic          pcAdvance,
    output logic          pcLoad,
    output logic [31:0]   pcTarget,
    output logic          branchTaken
);

    typedef enum logic [1:0] {
        Idle,
        Request,
        Await,
        Issue
    } seqState_e;

    seqState_e   state;
    seqState_e   nextState;
    logic        issueDone;
    logic        condMet;
    logic [31:0] jumpTarget;

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                nextState = Request;
            end
            Request: begin
                if (fetchReady) begin
                    nextState = Await; // address accepted by memory.
                end
            end
            Await: begin
                if (instrValid) begin
                    nextState = Issue;
                end
            end
            Issue: begin
                if (issueReady) begin
                    nextState = Request;
                end
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    assign fetchValid = (state == Request);
    assign instrReady = (state == Await);
    assign issueValid = (state == Issue);

    assign captureEn = instrReady && instrValid;
    assign issueDone = issueValid && issueReady;

    // branch resolution runs off the held word while in Issue.
    assign condMet     = decoded.branchOnZero ? (op1 == 32'd0) : (op1 != 32'd0);
    assign branchTaken = decoded.isUncondJump || (decoded.isCondJump && condMet);
    assign jumpTarget  = decoded.isAbsJump ? op1 : pc + decoded.immData;
    assign pcTarget    = branchTaken ? jumpTarget : pc + `FE_INSTR_STEP;

    assign pcLoad    = issueDone && branchTaken;
    assign pcAdvance = issueDone && !branchTaken;

endmodule

/* hw/frontEnd.sv */
`timescale 1ns/1ps
`include "frontEnd_cfg.svh"

module frontEnd import frontEndPkg::*; (
    input  logic         Clock,
    input  logic         rst,
    output logic         fetchValid,
    input  logic         fetchReady,
    output fetchReq_t    fetchReq,
    input  logic         instrValid,
    output logic         instrReady,
    input  logic [31:0]  instr,
    output logic         issueValid,
    input  logic         issueReady,
    output issuePacket_t issuePacket,
    input  writeBack_t   writeBack
);

    logic          captureEn;
    logic          pcAdvance;
    logic          pcLoad;
    logic [31:0]   pcTarget;
    logic [31:0]   pc;
    logic          branchTaken;
    decodedInstr_t decoded;
    logic [31:0]   op1;
    logic [31:0]   op2;

    fetchSequencer sequencer (
        .Clock       (Clock),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchReady  (fetchReady),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .issueValid  (issueValid),
        .issueReady  (issueReady),
        .decoded     (decoded),
        .pc          (pc),
        .op1         (op1),
        .captureEn   (captureEn),
        .pcAdvance   (pcAdvance),
        .pcLoad      (pcLoad),
        .pcTarget    (pcTarget),
        .branchTaken (branchTaken)
    );

    programCounter counter (
        .Clock     (Clock),
        .rst       (rst),
        .pcAdvance (pcAdvance),
        .pcLoad    (pcLoad),
        .pcTarget  (pcTarget),
        .pc        (pc)
    );

    instrDecoder decoder (
        .Clock     (Clock),
        .rst       (rst),
        .captureEn (captureEn),
        .instr     (instr),
        .decoded   (decoded)
    );

    regFile registers (
        .Clock     (Clock),
        .rst       (rst),
        .rdIndex1  (decoded.src1),
        .rdIndex2  (decoded.src2),
        .rdData1   (op1),
        .rdData2   (op2),
        .writeBack (writeBack)
    );

    assign fetchReq.addr = pc;

    assign issuePacket = '{
        pc:          pc,
        decoded:     decoded,
        op1:         op1,
        op2:         op2,
        branchTaken: branchTaken,
        linkAddr:    pc + `FE_INSTR_STEP // return address for JumpLink.
    };

endmodule

/* hw/frontEndPkg.sv */
package frontEndPkg;

    // opcodes that get special treatment in decode and branch resolution.
    typedef enum logic [5:0] {
        Load          = 6'b111000,
        LoadFloat     = 6'b111001,
        Store         = 6'b111010,
        StoreFloat    = 6'b111011,
        JumpReg       = 6'b111100,
        BranchZero    = 6'b111101,
        BranchNotZero = 6'b111110,
        JumpLink      = 6'b111111,
        Jump          = 6'b010000,
        AddUpper      = 6'b110000
    } opcode_e;

    typedef enum logic [1:0] {
        RegFmt   = 2'b00,
        JumpFmt  = 2'b01,
        ImmFmt   = 2'b10, // bit 1 set means immediate format.
        ImmFmtHi = 2'b11
    } format_e;

    typedef enum logic [1:0] {
        Arith   = 2'b00,
        Compare = 2'b01,
        Float   = 2'b10,
        Vector  = 2'b11
    } category_e;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] dest;
        logic [4:0] src1;
        logic [4:0] src2;
        logic [4:0] spare;
        logic [5:0] func;
    } regView_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  dest;
        logic [4:0]  src1;
        logic [15:0] imm;
    } immView_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] imm;
    } jumpView_t;

    typedef union packed {
        regView_t  regView;
        immView_t  immView;
        jumpView_t jumpView;
    } instrWord_u;

    typedef struct packed {
        logic [5:0]  src1;
        logic [5:0]  src2;
        logic [5:0]  dest;
        logic [31:0] immData;
        logic        immActive;
        logic [5:0]  funcCode;
        logic        isJumpLink;
        logic        isRelJump;
        logic        isAbsJump;
        logic        isLoad;
        logic        isStore;
        logic        isUncondJump;
        logic        isCondJump;
        logic        branchOnZero;
    } decodedInstr_t;

    typedef struct packed {
        logic [31:0] addr;
    } fetchReq_t;

    typedef struct packed {
        logic        valid;
        logic [5:0]  index;
        logic [31:0] data;
    } writeBack_t;

    typedef struct packed {
        logic [31:0]   pc;
        decodedInstr_t decoded;
        logic [31:0]   op1;
        logic [31:0]   op2;
        logic          branchTaken;
        logic [31:0]   linkAddr; // pc of the following instruction.
    } issuePacket_t;

endpackage

/* hw/frontEnd_cfg.svh */
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// address of the first fetch after reset.
`define FE_RESET_PC 32'h0000_0000

// byte distance between two sequential instructions.
`define FE_INSTR_STEP 32'd4

// integer registers 0..31, floating-point registers 32..63.
`define FE_NUM_REGS 64

`endif

/* hw/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import frontEndPkg::*; (
    input  logic          Clock,
    input  logic          rst,
    input  logic          captureEn,
    input  logic [31:0]   instr,
    output decodedInstr_t decoded
);

    instrWord_u word;
    logic [5:0] opcode;
    format_e    fmt;
    category_e  category;
    logic       isRegFmt;
    logic       isJumpFmt;
    logic       isImmFmt;
    logic       isFloatOp;

    always_ff @(posedge Clock) begin
        if (rst) begin
            word <= '0;
        end else if (captureEn) begin
            word <= instr;
        end
    end

    assign opcode   = word.regView.opcode;
    assign fmt      = format_e'(opcode[5:4]);
    assign category = category_e'(word.regView.func[5:4]);

    assign isRegFmt  = (fmt == RegFmt);
    assign isJumpFmt = (fmt == JumpFmt);
    assign isImmFmt  = fmt inside {ImmFmt, ImmFmtHi};
    assign isFloatOp = isRegFmt && (category == Float);

    // register indices, bit 5 selects the float half of the file.
    always_comb begin
        decoded.src1 = {isFloatOp, word.regView.src1};

        if (opcode == Store) begin
            decoded.src2 = {1'b0, word.regView.dest}; // store data sits in the dest field.
        end else if (opcode == StoreFloat) begin
            decoded.src2 = {1'b1, word.regView.dest};
        end else begin
            decoded.src2 = {isFloatOp, word.regView.src2};
        end

        if ((opcode == LoadFloat) || (opcode == StoreFloat) ||
            (isFloatOp && (word.regView.func[3:0] < 4'd8))) begin
            decoded.dest = {1'b1, word.regView.dest}; // float result.
        end else if (isRegFmt || isImmFmt) begin
            decoded.dest = {1'b0, word.regView.dest};
        end else begin
            decoded.dest = 6'd0;
        end
    end

    // immediate value.
    always_comb begin
        if (isJumpFmt) begin
            decoded.immData = {6'd0, word.jumpView.imm};
        end else if (opcode == AddUpper) begin
            decoded.immData = {word.immView.imm, 16'd0};
        end else if (isImmFmt) begin
            decoded.immData = {{16{word.immView.imm[15]}}, word.immView.imm};
        end else begin
            decoded.immData = 32'd0;
        end
    end

    assign decoded.immActive = isJumpFmt || isImmFmt;

    always_comb begin
        if (isRegFmt) begin
            decoded.funcCode = word.regView.func;
        end else if ((opcode == AddUpper) || isJumpFmt || (opcode >= Load)) begin
            decoded.funcCode = 6'd0;
        end else begin
            decoded.funcCode = {1'b0, opcode[4:0]}; // immediate ops reuse the opcode tail.
        end
    end

    // control flags.
    assign decoded.isJumpLink   = (opcode == JumpLink);
    assign decoded.isRelJump    = (opcode == JumpLink) || (opcode == Jump) ||
                                  (opcode == BranchZero) || (opcode == BranchNotZero);
    assign decoded.isAbsJump    = (opcode == JumpReg);
    assign decoded.isLoad       = (opcode == Load) || (opcode == LoadFloat);
    assign decoded.isStore      = (opcode == Store) || (opcode == StoreFloat);
    assign decoded.isUncondJump = (opcode == JumpReg) || (opcode == JumpLink) ||
                                  (opcode == Jump);
    assign decoded.isCondJump   = (opcode == BranchZero) || (opcode == BranchNotZero);
    assign decoded.branchOnZero = (opcode == BranchZero);

endmodule

/* hw/programCounter.sv */
`timescale 1ns/1ps
`include "frontEnd_cfg.svh"

module programCounter (
    input  logic        Clock,
    input  logic        rst,
    input  logic        pcAdvance,
    input  logic        pcLoad,
    input  logic [31:0] pcTarget,
    output logic [31:0] pc
);

    logic [31:0] pcNext;

    // a resolved branch target wins over the sequential step.
    always_comb begin
        if (pcLoad) begin
            pcNext = pcTarget;
        end else if (pcAdvance) begin
            pcNext = pc + `FE_INSTR_STEP;
        end else begin
            pcNext = pc;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            pc <= `FE_RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps
`include "frontEnd_cfg.svh"

module regFile import frontEndPkg::*; (
    input  logic        Clock,
    input  logic        rst,
    input  logic [5:0]  rdIndex1,
    input  logic [5:0]  rdIndex2,
    output logic [31:0] rdData1,
    output logic [31:0] rdData2,
    input  writeBack_t  writeBack
);

    logic [31:0] regs [`FE_NUM_REGS];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < `FE_NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (writeBack.valid && (writeBack.index != 6'd0)) begin
            regs[writeBack.index] <= writeBack.data;
        end
    end

    // register 0 is hardwired to zero.
    assign rdData1 = (rdIndex1 == 6'd0) ? 32'd0 : regs[rdIndex1];
    assign rdData2 = (rdIndex2 == 6'd0) ? 32'd0 : regs[rdIndex2];

endmodule

/* testbench/frontEnd_props.sv */
`timescale 1ns/1ps

module frontEnd_props import frontEndPkg::*; (
    input logic         Clock,
    input logic         rst,
    input logic         fetchValid,
    input logic         fetchReady,
    input fetchReq_t    fetchReq,
    input logic         instrValid,
    input logic         instrReady,
    input logic [31:0]  instr,
    input logic         issueValid,
    input logic         issueReady,
    input issuePacket_t issuePacket
);

    fetchHold: assert property (@(posedge Clock) disable iff (rst)
        fetchValid && !fetchReady |=> fetchValid && $stable(fetchReq))
        else $error("fetch request dropped or changed before fetchReady");

    instrHold: assert property (@(posedge Clock) disable iff (rst)
        instrValid && !instrReady |=> instrValid && $stable(instr))
        else $error("instruction word dropped or changed before instrReady");

    issueHold: assert property (@(posedge Clock) disable iff (rst)
        issueValid && !issueReady |=> issueValid && $stable(issuePacket))
        else $error("issue packet dropped or changed before issueReady");

    // one channel at a time.
    oneActive: assert property (@(posedge Clock) disable iff (rst)
        $onehot0({fetchValid, instrReady, issueValid}))
        else $error("more than one channel active");

    resetQuiet: assert property (@(posedge Clock)
        rst |=> !fetchValid && !instrReady && !issueValid)
        else $error("handshake outputs high during reset");

endmodule

/* testbench/frontEnd_tb.sv */
`timescale 1ns/1ps
`include "frontEnd_cfg.svh"

module frontEnd_tb import frontEndPkg::*; ();

    localparam int maxWaitCycles = 200;
    localparam int maxFetches = 64;
    localparam int pathLength = 20; // instructions on the executed path of the program.
    localparam logic [31:0] endPc = 32'd128;

    logic         Clock = 1'b0;
    logic         rst;
    logic         fetchValid;
    logic         fetchReady;
    fetchReq_t    fetchReq;
    logic         instrValid;
    logic         instrReady;
    logic [31:0]  instr;
    logic         issueValid;
    logic         issueReady;
    issuePacket_t issuePacket;
    writeBack_t   writeBack;

    logic [31:0]  imem [64];
    logic [31:0]  regModel [`FE_NUM_REGS];
    logic [31:0]  expectedPc;
    logic         instrSeen;
    logic         programDone;
    int           issueCount;
    int           fetches;
    issuePacket_t expected;

    frontEnd UUT (
        .Clock       (Clock),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchReady  (fetchReady),
        .fetchReq    (fetchReq),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .instr       (instr),
        .issueValid  (issueValid),
        .issueReady  (issueReady),
        .issuePacket (issuePacket),
        .writeBack   (writeBack)
    );

    bind frontEnd frontEnd_props props (
        .Clock       (Clock),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchReady  (fetchReady),
        .fetchReq    (fetchReq),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .instr       (instr),
        .issueValid  (issueValid),
        .issueReady  (issueReady),
        .issuePacket (issuePacket)
    );

    always #4 Clock = ~Clock;

    function automatic logic [31:0] regWord(input logic [5:0] op, input logic [4:0] dest,
                                            input logic [4:0] src1, input logic [4:0] src2,
                                            input logic [5:0] func);
        return {op, dest, src1, src2, 5'd0, func};
    endfunction

    function automatic logic [31:0] immWord(input logic [5:0] op, input logic [4:0] dest,
                                            input logic [4:0] src1, input logic [15:0] imm);
        return {op, dest, src1, imm};
    endfunction

    function automatic logic [31:0] jumpWord(input logic [5:0] op, input logic [25:0] imm);
        return {op, imm};
    endfunction

    // expected packet, built straight from the field layout of the word.
    function automatic issuePacket_t refDecode(input logic [31:0] pc, input logic [31:0] w,
                                               input logic [31:0] regs [`FE_NUM_REGS]);
        issuePacket_t p;
        logic [5:0]   op;
        logic [1:0]   fmt;
        logic         isFloat;
        op = w[31:26];
        fmt = w[31:30];
        isFloat = (fmt == 2'b00) && (w[5:4] == 2'b10);
        p = '0;
        p.pc = pc;
        p.linkAddr = pc + `FE_INSTR_STEP;
        p.decoded.src1 = {isFloat, w[20:16]};
        p.decoded.src2 = {isFloat, w[15:11]};
        if (op == Store || op == StoreFloat) begin
            p.decoded.src2 = {op == StoreFloat, w[25:21]};
        end
        p.decoded.dest = (fmt == 2'b01) ? 6'd0 : {1'b0, w[25:21]};
        if ((isFloat && w[3:0] < 4'd8) || op == LoadFloat || op == StoreFloat) begin
            p.decoded.dest[5] = 1'b1;
        end
        if (fmt == 2'b01) begin
            p.decoded.immData = {6'd0, w[25:0]};
        end else if (op == AddUpper) begin
            p.decoded.immData = {w[15:0], 16'd0};
        end else if (fmt[1]) begin
            p.decoded.immData = {{16{w[15]}}, w[15:0]};
        end
        p.decoded.immActive = (fmt != 2'b00);
        if (fmt == 2'b00) begin
            p.decoded.funcCode = w[5:0];
        end else if (!(op == AddUpper || fmt == 2'b01 || op >= Load)) begin
            p.decoded.funcCode = {1'b0, w[30:26]};
        end
        p.decoded.isJumpLink = (op == JumpLink);
        p.decoded.isRelJump = op inside {JumpLink, Jump, BranchZero, BranchNotZero};
        p.decoded.isAbsJump = (op == JumpReg);
        p.decoded.isLoad = (op == Load || op == LoadFloat);
        p.decoded.isStore = (op == Store || op == StoreFloat);
        p.decoded.isUncondJump = op inside {JumpReg, JumpLink, Jump};
        p.decoded.isCondJump = (op == BranchZero || op == BranchNotZero);
        p.decoded.branchOnZero = (op == BranchZero);
        p.op1 = (p.decoded.src1 == 6'd0) ? 32'd0 : regs[p.decoded.src1];
        p.op2 = (p.decoded.src2 == 6'd0) ? 32'd0 : regs[p.decoded.src2];
        p.branchTaken = p.decoded.isUncondJump || (p.decoded.isCondJump &&
                        ((op == BranchZero) == (p.op1 == 32'd0)));
        return p;
    endfunction

    function automatic logic [31:0] refNextPc(input issuePacket_t p);
        if (!p.branchTaken) begin
            return p.pc + `FE_INSTR_STEP;
        end
        return p.decoded.isAbsJump ? p.op1 : p.pc + p.decoded.immData;
    endfunction

    task automatic checkValue(input string what, input logic [255:0] got,
                              input logic [255:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic stepCycle();
        @(negedge Clock);
        issueReady = ($urandom_range(3) != 0); // stall issue about one cycle in four.
    endtask

    task automatic writeRegister(input logic [5:0] index, input logic [31:0] data);
        writeBack.valid = 1'b1;
        writeBack.index = index;
        writeBack.data = data;
        @(negedge Clock);
    endtask

    task automatic loadRegisters();
        regModel[0] = 32'd0;
        for (int i = 1; i < `FE_NUM_REGS; i++) begin
            regModel[i] = $urandom;
        end
        regModel[5] = 32'd0; // zero source for the branches.
        regModel[6] = regModel[6] | 32'd1;
        regModel[7] = 32'd96; // JumpReg target.
        for (int i = 0; i < `FE_NUM_REGS; i++) begin
            writeRegister(6'(i), (i == 0) ? 32'hFFFF_FFFF : regModel[i]); // r0 write is dropped.
        end
        writeBack = '0;
    endtask

    task automatic buildProgram();
        for (int i = 0; i < 64; i++) begin
            imem[i] = (32'(i) << 2) ^ 32'hA5C3_5A3C;
        end
        imem[0]  = regWord(6'h01, 5'd3, 5'd1, 5'd2, 6'h05);
        imem[1]  = regWord(6'h02, 5'd4, 5'd0, 5'd8, 6'h1A); // compare, src1 is r0.
        imem[2]  = regWord(6'h03, 5'd11, 5'd9, 5'd10, 6'h23); // float op with float dest.
        imem[3]  = regWord(6'h04, 5'd12, 5'd13, 5'd14, 6'h2C);
        imem[4]  = regWord(6'h05, 5'd15, 5'd16, 5'd17, 6'h31);
        imem[5]  = immWord(6'h25, 5'd18, 5'd19, 16'hFFF0);
        imem[6]  = immWord(6'h2A, 5'd1, 5'd2, 16'h1234);
        imem[7]  = immWord(AddUpper, 5'd20, 5'd0, 16'hABCD);
        imem[8]  = immWord(Load, 5'd21, 5'd22, 16'h0010);
        imem[9]  = immWord(LoadFloat, 5'd23, 5'd24, 16'h8000);
        imem[10] = immWord(Store, 5'd25, 5'd26, 16'h0004);
        imem[11] = immWord(StoreFloat, 5'd27, 5'd28, 16'hFFF8);
        imem[12] = jumpWord(Jump, 26'd16); // 48 to 64.
        imem[16] = jumpWord(JumpLink, 26'd16); // 64 to 80.
        imem[20] = immWord(JumpReg, 5'd0, 5'd7, 16'h0000); // 80 to 96.
        imem[24] = immWord(BranchZero, 5'd0, 5'd5, 16'h0008); // taken, 96 to 104.
        imem[26] = immWord(BranchZero, 5'd0, 5'd6, 16'h0040);
        imem[27] = immWord(BranchNotZero, 5'd0, 5'd6, 16'h000C); // taken, 108 to 120.
        imem[30] = immWord(BranchNotZero, 5'd0, 5'd5, 16'hFFC0);
        imem[31] = regWord(6'h00, 5'd0, 5'd0, 5'd0, 6'h00);
    endtask

    // memory side of one fetch: accept the address, then return the word.
    task automatic serveFetch();
        int          waited;
        logic [31:0] addr;
        waited = 0;
        while (!fetchValid) begin
            stepCycle();
            waited++;
            if (waited > maxWaitCycles) begin
                abortRun("Timeout: the DUT raised no fetch request.");
            end
        end
        if (programDone) begin
            return; // the path has ended, this fetch is left pending.
        end
        repeat ($urandom_range(1)) stepCycle();
        addr = fetchReq.addr;
        fetchReady = 1'b1;
        stepCycle();
        fetchReady = 1'b0;
        repeat ($urandom_range(3)) stepCycle();
        instrValid = 1'b1;
        instr = imem[addr[7:2]];
        waited = 0;
        while (!instrReady) begin
            stepCycle();
            waited++;
            if (waited > maxWaitCycles) begin
                abortRun("Timeout: the DUT never became ready for the instruction.");
            end
        end
        stepCycle();
        instrValid = 1'b0;
    endtask

    always @(posedge Clock) begin
        if (!rst) begin
            if (instrSeen) begin
                checkValue("issueValid after instruction", 256'(issueValid), 256'(1'b1));
            end
            instrSeen = instrValid && instrReady;
            if (fetchValid && fetchReady) begin
                checkValue("fetch address", 256'(fetchReq.addr), 256'(expectedPc));
            end
            if (issueValid && issueReady) begin
                expected = refDecode(expectedPc, imem[expectedPc[7:2]], regModel);
                checkValue("packet pc", 256'(issuePacket.pc), 256'(expected.pc));
                checkValue($sformatf("decoded fields at pc %0h", expectedPc),
                           256'(issuePacket.decoded), 256'(expected.decoded));
                checkValue("op1", 256'(issuePacket.op1), 256'(expected.op1));
                checkValue("op2", 256'(issuePacket.op2), 256'(expected.op2));
                checkValue("branchTaken", 256'(issuePacket.branchTaken),
                           256'(expected.branchTaken));
                checkValue("linkAddr", 256'(issuePacket.linkAddr), 256'(expected.linkAddr));
                expectedPc = refNextPc(expected);
                issueCount++;
                if (expectedPc == endPc) begin
                    programDone = 1'b1;
                end
            end
        end
    end

    initial begin
        void'($urandom(42));
        rst = 1'b1;
        fetchReady = 1'b0;
        instrValid = 1'b0;
        instr = 32'd0;
        issueReady = 1'b0;
        writeBack = '0;
        expectedPc = `FE_RESET_PC;
        instrSeen = 1'b0;
        programDone = 1'b0;
        issueCount = 0;
        fetches = 0;
        buildProgram();
        repeat (2) @(negedge Clock);
        rst = 1'b0;
        loadRegisters();
        while (!programDone) begin
            serveFetch();
            fetches++;
            if (fetches > maxFetches) begin
                abortRun("The program never reached its end address.");
            end
        end
        stepCycle();
        checkValue("fetch request after the last issue", 256'(fetchValid), 256'(1'b1));
        checkValue("fetch address after the last issue", 256'(fetchReq.addr), 256'(endPc));
        if (issueCount == pathLength) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Issued %0d instructions instead of %0d.", issueCount, pathLength);
            $display("Simulation failed");
            $fatal(1, "wrong instruction count");
        end
    end

endmodule
